// File: hw/alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

    parameter int reg_addr_w = 5;
    parameter int reg_count = 32;
    parameter int apb_addr_w = 8;    // 8-byte word per register
    parameter int imm_w = 12;        // i-type immediate

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_sll  = 3'd5,    // shift by low bits of b
        op_srl  = 3'd6,
        op_addi = 3'd7     // b is the immediate
    } alu_op_e;

    typedef enum logic {
        apb_idle,
        apb_access
    } apb_state_e;

endpackage

`default_nettype wire

// File: hw/pipe_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface issue_bus
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input wire clk
);
    logic                  valid;
    alu_op_e               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;    // sign-extended at issue

    modport src (output valid, op, rd, rs1, rs2, imm);
    modport dst (input clk, valid, op, rd, rs1, rs2, imm);
endinterface

interface result_bus
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
);
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;

    modport src (output valid, rd, data);
    modport snoop (input valid, rd, data);
endinterface

`default_nettype wire

// File: hw/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   issue_valid,
    input  wire alu_op_e          issue_op,
    input  wire  [reg_addr_w-1:0] issue_rd,
    input  wire  [reg_addr_w-1:0] issue_rs1,
    input  wire  [reg_addr_w-1:0] issue_rs2,
    input  wire  [imm_w-1:0]      issue_imm,
    issue_bus.src                 issue,
    output logic [reg_addr_w-1:0] rd_addr1,
    output logic [reg_addr_w-1:0] rd_addr2
);
    logic                  valid_q;
    alu_op_e               op_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [reg_addr_w-1:0] rs1_q;
    logic [reg_addr_w-1:0] rs2_q;
    logic [xlen-1:0]       imm_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin    // slot payload only matters when valid
            op_q  <= issue_op;
            rd_q  <= issue_rd;
            rs1_q <= issue_rs1;
            rs2_q <= issue_rs2;
            imm_q <= {{(xlen - imm_w){issue_imm[imm_w-1]}}, issue_imm};
        end
    end

    assign issue.valid = valid_q;
    assign issue.op    = op_q;
    assign issue.rd    = rd_q;
    assign issue.rs1   = rs1_q;
    assign issue.rs2   = rs2_q;
    assign issue.imm   = imm_q;

    assign rd_addr1 = rs1_q;    // regfile read during decode
    assign rd_addr2 = rs2_q;

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [reg_addr_w-1:0] rd_addr1,
    input  wire  [reg_addr_w-1:0] rd_addr2,
    output logic [xlen-1:0]       rd_data1,
    output logic [xlen-1:0]       rd_data2,
    result_bus.snoop              wb_res,
    input  wire                   host_wen,
    input  wire  [reg_addr_w-1:0] host_idx,
    input  wire  [xlen-1:0]       host_wdata,
    output logic [xlen-1:0]       host_rdata
);
    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_res.valid && wb_res.rd != '0) begin
            regs[wb_res.rd] <= wb_res.data;    // pipeline wins
        end else if (host_wen && host_idx != '0) begin
            regs[host_idx] <= host_wdata;
        end
    end

    assign rd_data1   = regs[rd_addr1];    // entry 0 never written
    assign rd_data2   = regs[rd_addr2];
    assign host_rdata = regs[host_idx];

    // neither the pipeline nor the host may ever land a value in x0
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: hw/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module operand_bypass
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    issue_bus.dst           issue,
    result_bus.snoop        ex_res,
    result_bus.snoop        wb_res,
    input  wire  [xlen-1:0] rd_data1,
    input  wire  [xlen-1:0] rd_data2,
    output logic [xlen-1:0] opnd_a,
    output logic [xlen-1:0] opnd_b
);
    typedef enum logic [1:0] {sel_zero, sel_ex, sel_wb, sel_rf} fwd_sel_e;

    fwd_sel_e        sel_a;
    fwd_sel_e        sel_b;
    logic [xlen-1:0] rs2_val;

    // newest producer first
    function automatic fwd_sel_e pick(
        input logic [reg_addr_w-1:0] idx,
        input logic                  ex_v,
        input logic [reg_addr_w-1:0] ex_rd,
        input logic                  wb_v,
        input logic [reg_addr_w-1:0] wb_rd
    );
        if (idx == '0) return sel_zero;
        if (ex_v && ex_rd == idx) return sel_ex;
        if (wb_v && wb_rd == idx) return sel_wb;
        return sel_rf;
    endfunction

    assign sel_a = pick(issue.rs1, ex_res.valid, ex_res.rd, wb_res.valid, wb_res.rd);
    assign sel_b = pick(issue.rs2, ex_res.valid, ex_res.rd, wb_res.valid, wb_res.rd);

    always_comb begin
        case (sel_a)
            sel_zero: opnd_a = '0;
            sel_ex:   opnd_a = ex_res.data;
            sel_wb:   opnd_a = wb_res.data;
            default:  opnd_a = rd_data1;
        endcase
    end

    always_comb begin
        case (sel_b)
            sel_zero: rs2_val = '0;
            sel_ex:   rs2_val = ex_res.data;
            sel_wb:   rs2_val = wb_res.data;
            default:  rs2_val = rd_data2;
        endcase
    end

    assign opnd_b = (issue.op == op_addi) ? issue.imm : rs2_val;    // imm already extended

    a_no_x0_fwd: assert property (@(posedge issue.clk) issue.valid |->
        (issue.rs1 != '0 || opnd_a == '0) &&
        (issue.rs2 != '0 || issue.op == op_addi || opnd_b == '0))
        else $error("in-flight result forwarded for x0");

endmodule

`default_nettype wire

// File: hw/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire            clk,
    input  wire            rst_n,
    issue_bus.dst          issue,
    input  wire [xlen-1:0] opnd_a,
    input  wire [xlen-1:0] opnd_b,
    result_bus.src         ex_res
);
    localparam int sh_w = $clog2(xlen);

    logic                  valid_q;
    alu_op_e               op_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       a_q;
    logic [xlen-1:0]       b_q;
    logic [xlen-1:0]       result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;    // bubble when decode slot empty
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            op_q <= issue.op;
            rd_q <= issue.rd;
            a_q  <= opnd_a;
            b_q  <= opnd_b;
        end
    end

    always_comb begin
        case (op_q)
            op_add, op_addi: result = a_q + b_q;
            op_sub:          result = a_q - b_q;
            op_and:          result = a_q & b_q;
            op_or:           result = a_q | b_q;
            op_xor:          result = a_q ^ b_q;
            op_sll:          result = a_q << b_q[sh_w-1:0];
            op_srl:          result = a_q >> b_q[sh_w-1:0];    // logical
            default:         result = '0;
        endcase
    end

    assign ex_res.valid = valid_q;
    assign ex_res.rd    = rd_q;
    assign ex_res.data  = result;

    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> op_q inside {op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_addi})
        else $error("execute holds an undefined opcode");

endmodule

`default_nettype wire

// File: hw/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire                   clk,
    input  wire                   rst_n,
    result_bus.snoop              ex_res,
    result_bus.src                wb_res,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_data
);
    logic                  valid_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_res.valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_q   <= ex_res.rd;
        data_q <= ex_res.data;
    end

    assign wb_res.valid = valid_q && rd_q != '0;    // x0 results only retire
    assign wb_res.rd    = rd_q;
    assign wb_res.data  = data_q;

    assign retire_valid = valid_q;
    assign retire_rd    = rd_q;
    assign retire_data  = data_q;

endmodule

`default_nettype wire

// File: hw/apb_reg_port.sv
`timescale 1ns/1ns
`default_nettype none

module apb_reg_port
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire  [apb_addr_w-1:0] paddr,
    input  wire  [xlen-1:0]       pwdata,
    output logic [xlen-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr,
    result_bus.snoop              wb_res,
    output logic                  host_wen,
    output logic [reg_addr_w-1:0] host_idx,
    output logic [xlen-1:0]       host_wdata,
    input  wire  [xlen-1:0]       host_rdata
);
    apb_state_e state;
    apb_state_e state_nxt;
    logic       misaligned;
    logic       wr_stall;

    assign misaligned = |paddr[2:0];
    assign wr_stall   = pwrite && !misaligned && wb_res.valid;    // writeback owns the port

    assign pready  = (state == apb_access) && !wr_stall;
    assign pslverr = (state == apb_access) && misaligned;
    assign prdata  = host_rdata;

    assign host_idx   = paddr[3 +: reg_addr_w];
    assign host_wdata = pwdata;
    assign host_wen   = (state == apb_access) && pwrite && !misaligned && !wb_res.valid;

    always_comb begin
        state_nxt = state;
        case (state)
            apb_idle:   if (psel && !penable) state_nxt = apb_access;    // setup seen
            apb_access: if (pready) state_nxt = apb_idle;
            default:    state_nxt = apb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= apb_idle;
        end else begin
            state <= state_nxt;
        end
    end

    a_apb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !pready) |=> $stable(paddr) && $stable(pwrite))
        else $error("paddr or pwrite changed before pready");

endmodule

`default_nettype wire

// File: hw/alu_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_pipe_top
    import alu_pipe_pkg::*;
#(
    parameter int xlen = 64
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  issue_valid,
    input  wire alu_op_e         issue_op,
    input  wire [reg_addr_w-1:0] issue_rd,
    input  wire [reg_addr_w-1:0] issue_rs1,
    input  wire [reg_addr_w-1:0] issue_rs2,
    input  wire [imm_w-1:0]      issue_imm,
    output wire                  retire_valid,
    output wire [reg_addr_w-1:0] retire_rd,
    output wire [xlen-1:0]       retire_data,
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  wire [apb_addr_w-1:0] paddr,
    input  wire [xlen-1:0]       pwdata,
    output wire [xlen-1:0]       prdata,
    output wire                  pready,
    output wire                  pslverr
);
    wire [reg_addr_w-1:0] rd_addr1;
    wire [reg_addr_w-1:0] rd_addr2;
    wire [xlen-1:0]       rd_data1;
    wire [xlen-1:0]       rd_data2;
    wire [xlen-1:0]       opnd_a;
    wire [xlen-1:0]       opnd_b;
    wire                  host_wen;
    wire [reg_addr_w-1:0] host_idx;
    wire [xlen-1:0]       host_wdata;
    wire [xlen-1:0]       host_rdata;

    issue_bus #(.xlen(xlen)) u_issue_bus (.clk(clk));
    result_bus #(.xlen(xlen)) u_ex_res ();
    result_bus #(.xlen(xlen)) u_wb_res ();

    issue_stage #(.xlen(xlen)) u_issue (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .issue(u_issue_bus.src), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2)
    );

    regfile #(.xlen(xlen)) u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .wb_res(u_wb_res.snoop),
        .host_wen(host_wen), .host_idx(host_idx),
        .host_wdata(host_wdata), .host_rdata(host_rdata)
    );

    operand_bypass #(.xlen(xlen)) u_bypass (
        .issue(u_issue_bus.dst), .ex_res(u_ex_res.snoop), .wb_res(u_wb_res.snoop),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .opnd_a(opnd_a), .opnd_b(opnd_b)
    );

    exec_stage #(.xlen(xlen)) u_exec (
        .clk(clk), .rst_n(rst_n), .issue(u_issue_bus.dst),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .ex_res(u_ex_res.src)
    );

    writeback_stage #(.xlen(xlen)) u_wb (
        .clk(clk), .rst_n(rst_n),
        .ex_res(u_ex_res.snoop), .wb_res(u_wb_res.src),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    apb_reg_port #(.xlen(xlen)) u_apb (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .wb_res(u_wb_res.snoop),
        .host_wen(host_wen), .host_idx(host_idx),
        .host_wdata(host_wdata), .host_rdata(host_rdata)
    );

endmodule

`default_nettype wire

// File: verif/tb_alu_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu_pipe
    import alu_pipe_pkg::*;
();
    localparam int xlen = 64;
    localparam int sh_w = $clog2(xlen);
    localparam int retire_timeout = 20;    // cycles
    localparam int apb_timeout = 50;

    typedef struct packed {
        alu_op_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [imm_w-1:0]      imm;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    alu_op_e               issue_op;
    logic [reg_addr_w-1:0] issue_rd;
    logic [reg_addr_w-1:0] issue_rs1;
    logic [reg_addr_w-1:0] issue_rs2;
    logic [imm_w-1:0]      issue_imm;
    wire                   retire_valid;
    wire  [reg_addr_w-1:0] retire_rd;
    wire  [xlen-1:0]       retire_data;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [xlen-1:0]       pwdata;
    wire  [xlen-1:0]       prdata;
    wire                   pready;
    wire                   pslverr;

    row_t                  rows[$];
    int                    sec_start[6];    // start of each table section plus the end
    logic [xlen-1:0]       model_regs[reg_count];
    logic [reg_addr_w-1:0] exp_rd[$];
    logic [xlen-1:0]       exp_data[$];
    int                    exp_cyc[$];
    int                    cyc;
    logic [31:0]           lfsr_q;

    alu_pipe_top #(.xlen(xlen)) dut (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;    // taps 32,22,2,1
        end
        return n;
    endfunction

    function automatic logic [xlen-1:0] draw_bits(input int n);
        logic [xlen-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[xlen-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [xlen-1:0] sign_extend(input logic [imm_w-1:0] imm);
        logic signed [xlen-1:0] v;
        v = $signed(imm);
        return v;
    endfunction

    // expected ALU behavior per opcode
    function automatic logic [xlen-1:0] alu_ref(input alu_op_e op, input logic [xlen-1:0] a,
                                               input logic [xlen-1:0] b);
        int amt;
        amt = int'(b[sh_w-1:0]);
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and:          return a & b;
            op_or:           return a | b;
            op_xor:          return a ^ b;
            op_sll:          return a << amt;
            op_srl:          return a >> amt;
            default:         return 'x;
        endcase
    endfunction

    function automatic logic [apb_addr_w-1:0] reg_addr(input int idx);
        return apb_addr_w'(idx * 8);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_data(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                                input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic compare_idx(input logic [reg_addr_w-1:0] got,
                               input logic [reg_addr_w-1:0] exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s is x%0d, expected x%0d",
                                        $time, what, got, exp));
        end
    endtask

    task automatic compare_apb_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic add_row(input alu_op_e op, input int rd, input int rs1, input int rs2,
                           input logic [xlen-1:0] imm);
        row_t r;
        r.op  = op;
        r.rd  = reg_addr_w'(rd);
        r.rs1 = reg_addr_w'(rs1);
        r.rs2 = reg_addr_w'(rs2);
        r.imm = imm[imm_w-1:0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        sec_start[0] = rows.size();    // independent ops on preloaded registers
        add_row(op_add,  10,  1,  2, '0);
        add_row(op_sub,  11,  3,  4, '0);
        add_row(op_and,  12,  5,  6, '0);
        add_row(op_or,   13,  7,  8, '0);
        add_row(op_xor,  14,  9, 15, '0);
        add_row(op_sll,  16, 17, 18, '0);
        add_row(op_srl,  19, 20, 21, '0);
        add_row(op_addi, 22, 23,  0, draw_bits(imm_w));
        sec_start[1] = rows.size();    // back-to-back chain
        add_row(op_add,  24,  1,  2, '0);
        add_row(op_sub,  25, 24,  3, '0);
        add_row(op_xor,  26,  4, 25, '0);
        add_row(op_add,  27, 26, 26, '0);
        add_row(op_sll,  28, 27,  5, '0);
        add_row(op_addi, 29, 28,  0, draw_bits(imm_w));
        add_row(op_or,   30, 29, 29, '0);
        add_row(op_srl,  31, 30, 30, '0);
        sec_start[2] = rows.size();    // distance two, same rd twice, x0 producers
        add_row(op_add,   5,  1,  2, '0);
        add_row(op_xor,   6,  3,  4, '0);
        add_row(op_sub,   7,  5,  6, '0);
        add_row(op_addi,  8,  1,  0, draw_bits(imm_w));
        add_row(op_addi,  8,  2,  0, draw_bits(imm_w));
        add_row(op_add,   9,  8,  8, '0);
        add_row(op_add,   0,  1,  2, '0);
        add_row(op_add,  10,  0,  3, '0);
        add_row(op_add,   0,  3,  4, '0);
        add_row(op_or,   12,  1,  2, '0);
        add_row(op_add,  13,  0,  1, '0);
        sec_start[3] = rows.size();    // keeps writeback busy under an APB write
        add_row(op_add,  20,  1,  2, '0);
        add_row(op_xor,  21,  3,  4, '0);
        add_row(op_or,   22,  5,  6, '0);
        add_row(op_sub,  23, 20,  7, '0);    // x20 comes from the register file here
        add_row(op_and,  24, 21,  8, '0);
        add_row(op_addi, 25, 23,  0, draw_bits(imm_w));
        sec_start[4] = rows.size();    // reads the host value of x20
        add_row(op_add,  26, 20,  0, '0);
        add_row(op_xor,  27, 25, 20, '0);
        sec_start[5] = rows.size();
    endtask

    task automatic issue_row(input row_t r);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        @(posedge clk);
        #2;
        issue_valid = 1'b1;
        issue_op    = r.op;
        issue_rd    = r.rd;
        issue_rs1   = r.rs1;
        issue_rs2   = r.rs2;
        issue_imm   = r.imm;
        a   = model_regs[r.rs1];    // model x0 stays zero
        b   = (r.op == op_addi) ? sign_extend(r.imm) : model_regs[r.rs2];
        res = alu_ref(r.op, a, b);
        if (r.rd != '0) begin
            model_regs[r.rd] = res;
        end
        exp_rd.push_back(r.rd);
        exp_data.push_back(res);
        exp_cyc.push_back(cyc + 3);    // sampled next edge and retired two edges later
    endtask

    task automatic run_section(input int sec);
        for (int i = sec_start[sec]; i < sec_start[sec + 1]; i++) begin
            issue_row(rows[i]);
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic check_retire();
        if (retire_valid !== 1'b1) begin
            if (exp_cyc.size() > 0 && exp_cyc[0] <= cyc) begin
                stop_with_failure($sformatf("result for x%0d did not retire in cycle %0d",
                                            exp_rd[0], exp_cyc[0]));
            end
        end else if (exp_cyc.size() == 0) begin
            stop_with_failure($sformatf("retire_valid rose in cycle %0d with no issue", cyc));
        end else begin
            if (exp_cyc[0] != cyc) begin
                stop_with_failure($sformatf("result retired in cycle %0d, due in cycle %0d",
                                            cyc, exp_cyc[0]));
            end
            compare_idx(retire_rd, exp_rd[0], "retire_rd");
            compare_data(retire_data, exp_data[0], $sformatf("retire_data of x%0d", exp_rd[0]));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_cyc.pop_front());
        end
    endtask

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc++;
            #1;
            check_retire();
        end
    end

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_cyc.size() != 0) begin
            if (waited == retire_timeout) begin
                stop_with_failure($sformatf("timeout with %0d results still not retired",
                                            exp_cyc.size()));
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic apb_transfer(input logic is_write, input logic [apb_addr_w-1:0] addr,
                                input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata,
                                output logic err);
        int waited;
        @(posedge clk);
        #2;
        psel    = 1'b1;    // setup
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waited  = 0;
        #1;
        while (pready !== 1'b1) begin
            if (waited == apb_timeout) begin
                stop_with_failure($sformatf("timeout with pready low for %0d cycles at paddr %h",
                                            waited, addr));
            end
            waited++;
            @(posedge clk);
            #3;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] data,
                             input logic exp_err);
        logic [xlen-1:0] rdata;
        logic            err;
        apb_transfer(1'b1, addr, data, rdata, err);
        compare_apb_err(err, exp_err, $sformatf("pslverr of write to %h", addr));
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] exp);
        logic [xlen-1:0] rdata;
        logic            err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        compare_apb_err(err, 1'b0, $sformatf("pslverr of read from %h", addr));
        compare_data(rdata, exp, $sformatf("prdata from %h", addr));
    endtask

    initial begin
        logic [xlen-1:0] v;
        issue_valid = 1'b0;
        issue_op    = op_add;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rst_n       = 1'b0;
        lfsr_q      = 32'haa1e88a9;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (retire_valid !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0) begin
            stop_with_failure($sformatf("FAILED at time %0t: outputs not idle after reset",
                                        $time));
        end

        apb_write(reg_addr(0), draw_bits(xlen), 1'b0);    // accepted, no effect
        for (int i = 1; i < reg_count; i++) begin
            v = draw_bits(xlen);
            apb_write(reg_addr(i), v, 1'b0);
            model_regs[i] = v;
        end
        for (int i = 0; i < reg_count; i++) begin
            apb_read(reg_addr(i), model_regs[i]);
        end

        for (int s = 0; s < 3; s++) begin
            run_section(s);
            wait_drain();
        end

        // host write stalls until the burst stops writing back, so it lands last
        v = draw_bits(xlen);
        fork
            run_section(3);
            begin
                repeat (3) @(posedge clk);
                apb_write(reg_addr(20), v, 1'b0);
            end
        join
        model_regs[20] = v;
        wait_drain();
        run_section(4);
        wait_drain();

        apb_write(reg_addr(3) | 8'h04, draw_bits(xlen), 1'b1);
        apb_read(reg_addr(3), model_regs[3]);

        for (int i = 0; i < reg_count; i++) begin
            apb_read(reg_addr(i), model_regs[i]);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/alu_pipe_pkg.sv
hw/pipe_bus_if.sv
hw/issue_stage.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/exec_stage.sv
hw/writeback_stage.sv
hw/apb_reg_port.sv
hw/alu_pipe_top.sv
verif/tb_alu_pipe.sv
